//--- hdl/oflow_mem_defs.svh
// field lengths and memory geometry of the tracker feature store
// include wherever rows or lanes are sliced, after the timescale line
`ifndef OFLOW_MEM_DEFS_SVH
`define OFLOW_MEM_DEFS_SVH

// box fields, from the high end of a box: cm, position, rest, id
`define OFLOW_ID_LEN               8    // object id
`define OFLOW_CM_CONCATE_LEN       44   // center of mass x and y
`define OFLOW_POSITION_CONCATE_LEN 44   // box corners
`define OFLOW_REST_LEN             49   // width, height, two colors
`define OFLOW_BOX_LEN              145  // one box
`define OFLOW_ROW_LEN              290  // left box on top, right box below

// macro geometry
`define OFLOW_NUM_LANES            6    // three lanes per box
`define OFLOW_LANE_WIDTH           64   // macro word
`define OFLOW_ADDR_WIDTH           8    // 256 rows

`endif

//--- hdl/oflow_feature_pkg.sv
// types for the bounding box features kept in the store
// imported by modules that handle whole rows or pick fields out of a box
`default_nettype none

`include "oflow_mem_defs.svh"

package oflow_feature_pkg;

  // object id, sits at the low end of each box
  typedef logic [`OFLOW_ID_LEN-1:0] obj_id_t;

  // concatenated center of mass, top of each box
  typedef logic [`OFLOW_CM_CONCATE_LEN-1:0] cm_t;

  // concatenated corners
  typedef logic [`OFLOW_POSITION_CONCATE_LEN-1:0] position_t;

  // width, height, color1, color2
  typedef logic [`OFLOW_REST_LEN-1:0] rest_t;

  // one box, high to low: cm | position | rest | id
  typedef logic [`OFLOW_BOX_LEN-1:0] box_t;

  // one row, left box in the upper half
  typedef logic [`OFLOW_ROW_LEN-1:0] row_t;

endpackage

`default_nettype wire

//--- hdl/oflow_mem_pkg.sv
// types for the macro side of the store: row address and lane words
// lane map, per box group of three:
//   first lane  {pad, id, cm}, cm in the low bits
//   second lane {pad, position}
//   third lane  {pad, rest}
// lanes 0..2 hold the left box, lanes 3..5 the right box
`default_nettype none

`include "oflow_mem_defs.svh"

package oflow_mem_pkg;

  // row address, same on every macro
  typedef logic [`OFLOW_ADDR_WIDTH-1:0] row_addr_t;

  // one macro word
  typedef logic [`OFLOW_LANE_WIDTH-1:0] lane_t;

  // all six lanes of a row, lane i at index i
  typedef logic [`OFLOW_NUM_LANES-1:0][`OFLOW_LANE_WIDTH-1:0] lane_array_t;

endpackage

`default_nettype wire

//--- hdl/oflow_mem_if.sv
// the two macro ports going from decode to the bank
// port 0 writes row 0 or reads, port 1 only writes row 1
// result taps port 0 controls to know when a read is in the macros
`timescale 1ns/10ps
`default_nettype none

interface oflow_mem_if
  import oflow_mem_pkg::*;
();

  // port 0
  row_addr_t   addr_0;
  logic        en_0;    // chip select
  logic        we_0;    // write when set, read otherwise
  lane_array_t lanes_0; // write data, one word per macro

  // port 1
  row_addr_t   addr_1;
  logic        en_1;
  logic        we_1;
  lane_array_t lanes_1;

  modport drive (
    output addr_0, en_0, we_0, lanes_0,
    output addr_1, en_1, we_1, lanes_1
  );

  modport mem (
    input addr_0, en_0, we_0, lanes_0,
    input addr_1, en_1, we_1, lanes_1
  );

  // read tracking needs only port 0 strobes
  modport track (
    input en_0, we_0
  );

endinterface

`default_nettype wire

//--- hdl/dpram_256x64.sv
// behavioral model of the 256x64 dual-port RAM macro
// both ports write on cs and we, port 2 lands last on the same address
// a selected port without we returns its word one clock later
`timescale 1ns/10ps
`default_nettype none

`include "oflow_mem_defs.svh"

module dpram_256x64
  import oflow_mem_pkg::*;
(
  input  logic      clk,
  input  row_addr_t a1,
  input  row_addr_t a2,
  input  logic      cs1,
  input  logic      cs2,
  input  logic      we1,
  input  logic      we2,
  input  lane_t     i1,
  input  lane_t     i2,
  output lane_t     o1,
  output lane_t     o2
);

  lane_t mem [0:(1 << `OFLOW_ADDR_WIDTH)-1]; // contents undefined at power up

  always_ff @(posedge clk) begin
    if (cs1 && we1) mem[a1] <= i1;
    if (cs2 && we2) mem[a2] <= i2; // later assignment wins on a clash
  end

  // registered reads, output holds otherwise
  always_ff @(posedge clk) begin
    if (cs1 && !we1) o1 <= mem[a1];
    if (cs2 && !we2) o2 <= mem[a2];
  end

endmodule

`default_nettype wire

//--- hdl/oflow_mem_decode.sv
// command stage of the feature store
// registers write and read strobes and splits each row into six lanes per port
// a write in the same cycle as a read wins, and the read is lost
`timescale 1ns/10ps
`default_nettype none

`include "oflow_mem_defs.svh"

module oflow_mem_decode
  import oflow_feature_pkg::*;
  import oflow_mem_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      wr_en,
  input  row_addr_t wr_addr_0,
  input  row_addr_t wr_addr_1,
  input  row_t      wr_row_0,
  input  row_t      wr_row_1,
  input  logic      rd_en,
  input  row_addr_t rd_addr,
  oflow_mem_if.drive ports
);

  logic rd_go; // read survives only without a write

  // row to six lanes by the lane map
  function automatic lane_array_t split_row(input row_t row);
    lane_array_t lanes;
    box_t        box;
    cm_t         cm;
    position_t   pos;
    rest_t       rest;
    obj_id_t     id;
    int          base;
    lanes = '0; // pad bits stay zero
    for (int b = 0; b < 2; b++) begin
      box  = (b == 0) ? row[`OFLOW_ROW_LEN-1 -: `OFLOW_BOX_LEN] : row[`OFLOW_BOX_LEN-1:0];
      base = b * (`OFLOW_NUM_LANES / 2); // 0 left, 3 right
      cm   = box[`OFLOW_BOX_LEN-1 -: `OFLOW_CM_CONCATE_LEN];
      pos  = box[`OFLOW_BOX_LEN-`OFLOW_CM_CONCATE_LEN-1 -: `OFLOW_POSITION_CONCATE_LEN];
      rest = box[`OFLOW_ID_LEN +: `OFLOW_REST_LEN];
      id   = box[`OFLOW_ID_LEN-1:0];
      lanes[base][`OFLOW_CM_CONCATE_LEN-1:0]             = cm;
      lanes[base][`OFLOW_CM_CONCATE_LEN +: `OFLOW_ID_LEN] = id; // id rides above cm
      lanes[base+1][`OFLOW_POSITION_CONCATE_LEN-1:0]      = pos;
      lanes[base+2][`OFLOW_REST_LEN-1:0]                  = rest;
    end
    return lanes;
  endfunction

  assign rd_go = rd_en & ~wr_en;

  // port strobes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ports.en_0 <= 1'b0;
      ports.we_0 <= 1'b0;
      ports.en_1 <= 1'b0;
      ports.we_1 <= 1'b0;
    end else begin
      ports.en_0 <= wr_en | rd_go;
      ports.we_0 <= wr_en;
      ports.en_1 <= wr_en; // port 1 never reads
      ports.we_1 <= wr_en;
    end
  end

  // port 0 address picks the write or the read
  always_ff @(posedge clk) begin
    ports.addr_0  <= wr_en ? wr_addr_0 : rd_addr;
    ports.addr_1  <= wr_addr_1;
    ports.lanes_0 <= split_row(wr_row_0);
    ports.lanes_1 <= split_row(wr_row_1);
  end

endmodule

`default_nettype wire

//--- hdl/oflow_mem_bank.sv
// bank of six RAM macros holding one feature row per address
// every macro shares the port controls and takes its own lane of data
// port 0 read words come back as one lane array, port 1 is write only
`timescale 1ns/10ps
`default_nettype none

`include "oflow_mem_defs.svh"

module oflow_mem_bank
  import oflow_mem_pkg::*;
(
  input  logic        clk,
  oflow_mem_if.mem    ports,
  output lane_array_t rd_lanes
);

  for (genvar g = 0; g < `OFLOW_NUM_LANES; g++) begin : g_lane
    // lane g of both rows goes into macro g
    dpram_256x64 u_ram (
      .clk (clk),
      .a1  (ports.addr_0),
      .a2  (ports.addr_1),
      .cs1 (ports.en_0),
      .cs2 (ports.en_1),
      .we1 (ports.we_0),
      .we2 (ports.we_1),
      .i1  (ports.lanes_0[g]),
      .i2  (ports.lanes_1[g]),
      .o1  (rd_lanes[g]),  // read data, one clock after en
      .o2  ()              // second read port not used
    );
  end

endmodule

`default_nettype wire

//--- hdl/oflow_mem_result.sv
// output stage of the feature store
// follows reads through the macro latency, rebuilds the row from its
// lanes and registers row and both ids with a one cycle valid pulse
`timescale 1ns/10ps
`default_nettype none

`include "oflow_mem_defs.svh"

module oflow_mem_result
  import oflow_feature_pkg::*;
  import oflow_mem_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  oflow_mem_if.track  ports,
  input  lane_array_t rd_lanes,
  output logic        rd_valid,
  output row_t        rd_row,
  output obj_id_t     rd_id_left,
  output obj_id_t     rd_id_right
);

  logic rd_pend; // macro data lands this cycle
  row_t row_join;

  // lanes -> row, inverse of the decode split
  function automatic row_t join_lanes(input lane_array_t lanes);
    row_t row;
    box_t box;
    int   base;
    row = '0;
    for (int b = 0; b < 2; b++) begin
      base = b * (`OFLOW_NUM_LANES / 2);
      box  = {lanes[base][`OFLOW_CM_CONCATE_LEN-1:0],
              lanes[base+1][`OFLOW_POSITION_CONCATE_LEN-1:0],
              lanes[base+2][`OFLOW_REST_LEN-1:0],
              lanes[base][`OFLOW_CM_CONCATE_LEN +: `OFLOW_ID_LEN]};
      if (b == 0) row[`OFLOW_ROW_LEN-1 -: `OFLOW_BOX_LEN] = box; // left on top
      else        row[`OFLOW_BOX_LEN-1:0] = box;
    end
    return row;
  endfunction

  assign row_join = join_lanes(rd_lanes);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pend  <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      rd_pend  <= ports.en_0 & ~ports.we_0; // a real read, not a write
      rd_valid <= rd_pend;
    end
  end

  // payload only moves on a read
  always_ff @(posedge clk) begin
    if (rd_pend) begin
      rd_row      <= row_join;
      rd_id_left  <= row_join[`OFLOW_BOX_LEN +: `OFLOW_ID_LEN];
      rd_id_right <= row_join[`OFLOW_ID_LEN-1:0];
    end
  end

endmodule

`default_nettype wire

//--- hdl/oflow_feature_mem.sv
// top of the tracker feature store
// wr_en stores two rows at two addresses, rd_en fetches one row plus
// both box ids three cycles later with rd_valid; never raise both strobes
`timescale 1ns/10ps
`default_nettype none

module oflow_feature_mem
  import oflow_feature_pkg::*;
  import oflow_mem_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      wr_en,
  input  row_addr_t wr_addr_0,
  input  row_addr_t wr_addr_1,
  input  row_t      wr_row_0,
  input  row_t      wr_row_1,
  input  logic      rd_en,
  input  row_addr_t rd_addr,
  output logic      rd_valid,
  output row_t      rd_row,
  output obj_id_t   rd_id_left,
  output obj_id_t   rd_id_right
);

  lane_array_t rd_lanes; // port 0 read words, bank to result

  oflow_mem_if u_ports ();

  oflow_mem_decode u_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en     (wr_en),
    .wr_addr_0 (wr_addr_0),
    .wr_addr_1 (wr_addr_1),
    .wr_row_0  (wr_row_0),
    .wr_row_1  (wr_row_1),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .ports     (u_ports.drive)
  );

  oflow_mem_bank u_bank (
    .clk      (clk),
    .ports    (u_ports.mem),
    .rd_lanes (rd_lanes)
  );

  oflow_mem_result u_result (
    .clk         (clk),
    .rst_n       (rst_n),
    .ports       (u_ports.track),
    .rd_lanes    (rd_lanes),
    .rd_valid    (rd_valid),
    .rd_row      (rd_row),
    .rd_id_left  (rd_id_left),
    .rd_id_right (rd_id_right)
  );

endmodule

`default_nettype wire

//--- verif/oflow_feature_mem_tb.sv
// testbench for the tracker feature store
// replays the pattern file, random idle gaps only in front of write pairs,
// so reads after a write or after each other go out on consecutive cycles
// every read is checked for row, both ids and its three cycle latency
`timescale 1ns/10ps
`default_nettype none

module oflow_feature_mem_tb
  import oflow_feature_pkg::*;
  import oflow_mem_pkg::*;
();

  localparam int IDLE_LIMIT  = 8;  // longest idle stretch allowed
  localparam int DRAIN_LIMIT = 10; // cycles left for the last results

  typedef struct packed {
    int      due;      // cycle count when rd_valid is expected
    row_t    row;
    obj_id_t id_left;
    obj_id_t id_right;
  } expect_t;

  logic      clk;
  logic      rst_n;
  logic      wr_en;
  row_addr_t wr_addr_0;
  row_addr_t wr_addr_1;
  row_t      wr_row_0;
  row_t      wr_row_1;
  logic      rd_en;
  row_addr_t rd_addr;
  logic      rd_valid;
  row_t      rd_row;
  obj_id_t   rd_id_left;
  obj_id_t   rd_id_right;

  expect_t   pending[$]; // reads in flight, oldest first
  int        cyc = 0;    // rising edges so far

  oflow_feature_mem dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_en       (wr_en),
    .wr_addr_0   (wr_addr_0),
    .wr_addr_1   (wr_addr_1),
    .wr_row_0    (wr_row_0),
    .wr_row_1    (wr_row_1),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .rd_valid    (rd_valid),
    .rd_row      (rd_row),
    .rd_id_left  (rd_id_left),
    .rd_id_right (rd_id_right)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period
  end

  always @(posedge clk) cyc <= cyc + 1;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_row(input string name, input row_t got, input row_t exp);
    if (got !== exp)
      abort_run($sformatf("[FAIL] %0t %s got %h exp %h", $time, name, got, exp));
  endtask

  task automatic check_id(input string name, input obj_id_t got, input obj_id_t exp);
    if (got !== exp)
      abort_run($sformatf("[FAIL] %0t %s got %h exp %h", $time, name, got, exp));
  endtask

  // n cycles with both strobes low
  task automatic idle_cycles(input int n);
    int waited;
    waited = 0;
    while (waited < n) begin
      if (waited >= IDLE_LIMIT) begin
        abort_run("an idle stretch ran past its limit");
      end else begin
        @(posedge clk);
        #1;
        wr_en = 1'b0;
        rd_en = 1'b0;
        waited++;
      end
    end
  endtask

  task automatic drive_write(input row_addr_t a0, input row_addr_t a1,
                             input row_t r0, input row_t r1);
    @(posedge clk);
    #1;
    wr_en     = 1'b1;
    rd_en     = 1'b0; // never both strobes at once
    wr_addr_0 = a0;
    wr_addr_1 = a1;
    wr_row_0  = r0;
    wr_row_1  = r1;
  endtask

  task automatic drive_read(input row_addr_t a, input row_t row,
                            input obj_id_t id_l, input obj_id_t id_r);
    expect_t e;
    @(posedge clk);
    #1;
    wr_en      = 1'b0;
    rd_en      = 1'b1;
    rd_addr    = a;
    e.due      = cyc + 3; // valid three cycles after the rd_en cycle
    e.row      = row;
    e.id_left  = id_l;
    e.id_right = id_r;
    pending.push_back(e);
  endtask

  // outputs sampled mid cycle, away from the driving edge
  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      if (rd_valid === 1'b1) begin
        if (pending.size() == 0) begin
          abort_run("rd_valid went high with no read in flight");
        end else begin
          if (cyc != pending[0].due)
            abort_run($sformatf("[FAIL] %0t rd_valid cycle got %0d exp %0d",
                                $time, cyc, pending[0].due));
          check_row("rd_row", rd_row, pending[0].row);
          check_id("rd_id_left", rd_id_left, pending[0].id_left);
          check_id("rd_id_right", rd_id_right, pending[0].id_right);
          void'(pending.pop_front());
        end
      end else if (rd_valid !== 1'b0) begin
        abort_run("rd_valid is unknown after reset");
      end else if (pending.size() != 0 && cyc >= pending[0].due) begin
        abort_run("timed out waiting for rd_valid of a read");
      end
    end
  end

  initial begin
    int        fd;
    int        n;
    int        gap;
    int        seed;
    int        waited;
    string     line;
    byte       kind;
    row_addr_t a0;
    row_addr_t a1;
    row_t      r0;
    row_t      r1;
    obj_id_t   id_l;
    obj_id_t   id_r;
    seed      = 70;
    gap       = $urandom(seed); // one seed for the whole run
    rst_n     = 1'b0;
    wr_en     = 1'b0;
    rd_en     = 1'b0;
    wr_addr_0 = '0;
    wr_addr_1 = '0;
    wr_row_0  = '0;
    wr_row_1  = '0;
    rd_addr   = '0;
    idle_cycles(4);
    rst_n = 1'b1;
    idle_cycles(3); // quiet after reset, rd_valid watched by the checker
    fd = $fopen("verif/oflow_mem_patterns.txt", "r");
    if (fd == 0) abort_run("cannot open the pattern file");
    while ($fgets(line, fd) != 0) begin
      kind = line[0];
      if (kind == "W") begin
        n = $sscanf(line, "%c %h %h %h %h", kind, a0, a1, r0, r1);
        if (n != 5) abort_run("malformed write line in the pattern file");
        gap = $urandom % 3; // 0 to 2 idle cycles
        idle_cycles(gap);
        drive_write(a0, a1, r0, r1);
      end else if (kind == "R") begin
        n = $sscanf(line, "%c %h %h %h %h", kind, a0, r0, id_l, id_r);
        if (n != 5) abort_run("malformed read line in the pattern file");
        drive_read(a0, r0, id_l, id_r);
      end else if (kind != "#" && line.len() > 1) begin
        abort_run("unknown command in the pattern file");
      end
    end
    $fclose(fd);
    idle_cycles(1);
    waited = 0;
    while (pending.size() != 0) begin
      if (waited >= DRAIN_LIMIT) begin
        abort_run("timed out waiting for the last read results");
      end else begin
        @(posedge clk);
        waited++;
      end
    end
    idle_cycles(2); // any stray rd_valid still gets flagged
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- oflow_feature_mem.f
+incdir+hdl
hdl/oflow_feature_pkg.sv
hdl/oflow_mem_pkg.sv
hdl/oflow_mem_if.sv
hdl/dpram_256x64.sv
hdl/oflow_mem_decode.sv
hdl/oflow_mem_bank.sv
hdl/oflow_mem_result.sv
hdl/oflow_feature_mem.sv
verif/oflow_feature_mem_tb.sv

//--- Bender.yml
package:
  name: oflow_feature_mem

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/oflow_feature_pkg.sv
      - hdl/oflow_mem_pkg.sv
      - hdl/oflow_mem_if.sv
      - hdl/dpram_256x64.sv
      - hdl/oflow_mem_decode.sv
      - hdl/oflow_mem_bank.sv
      - hdl/oflow_mem_result.sv
      - hdl/oflow_feature_mem.sv
  - target: test
    files:
      - verif/oflow_feature_mem_tb.sv

//--- verif/oflow_mem_patterns.txt
# W lines hold addr_0 addr_1 row_0 row_1 in hex, rows are 290 bits
# R lines hold addr, expected row, expected left id and right id in hex
W 10 20 20123456789abcdeffedcba9876543210514a13579bdf02468acec3c3c3c3c3c3c3c39e3c 1fedcba98765432100123456789abcdefa0f32468ace013579bdf5a5a5a5a5a5a5a5ad107
R 10 20123456789abcdeffedcba9876543210514a13579bdf02468acec3c3c3c3c3c3c3c39e3c a5 3c
R 20 1fedcba98765432100123456789abcdefa0f32468ace013579bdf5a5a5a5a5a5a5a5ad107 79 07
W 30 31 3deadbeefcafef00d0badc0de12345678972e8badf00d76543210aaaa5555aaaa555542e1 011112222333344445555666677778888fc900f1e2d3c4b5a69788796a5b4c3d2e1f066ff
R 30 3deadbeefcafef00d0badc0de12345678972e8badf00d76543210aaaa5555aaaa555542e1 97 e1
R 31 011112222333344445555666677778888fc900f1e2d3c4b5a69788796a5b4c3d2e1f066ff 48 ff
R 10 20123456789abcdeffedcba9876543210514a13579bdf02468acec3c3c3c3c3c3c3c39e3c a5 3c
W 40 40 2a5a5a5a5a5a5a5a500000000000000000b85ffffffffffffffff12341234123412340080 10000ffff0000ffff3333cccc3333cccc76a177778888999900aabbccddeeff001122335d
R 40 10000ffff0000ffff3333cccc3333cccc76a177778888999900aabbccddeeff001122335d 50 5d
W 20 41 2a5a5a5a5a5a5a5a500000000000000000b85ffffffffffffffff12341234123412340080 20123456789abcdeffedcba9876543210514a13579bdf02468acec3c3c3c3c3c3c3c39e3c
R 20 2a5a5a5a5a5a5a5a500000000000000000b85ffffffffffffffff12341234123412340080 c2 80
R 41 20123456789abcdeffedcba9876543210514a13579bdf02468acec3c3c3c3c3c3c3c39e3c a5 3c
R 30 3deadbeefcafef00d0badc0de12345678972e8badf00d76543210aaaa5555aaaa555542e1 97 e1
